//--- common/cpu_config.svh
// sizes and instruction field positions for the 16-bit pipelined CPU
// changing CPU_WORD_BITS alone is not enough; the mvt shift assumes 16 bits
// r7 doubles as the program counter and is only written by branches
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_WORD_BITS   16
`define CPU_NUM_REGS    8
`define CPU_REG_BITS    3
`define CPU_OPCODE_BITS 3
`define CPU_IMM_BITS    9
`define CPU_PC_REG      7

// instruction layout: opcode | imm flag | rX | imm9 or 000000 rY
`define CPU_IMM_FLAG    12
`define CPU_RX_LSB      9
`define CPU_RY_LSB      0

// bit positions inside flags_t
`define CPU_FLAG_N      2
`define CPU_FLAG_Z      1
`define CPU_FLAG_C      0

`endif

//--- common/cpu_pkg.sv
// shared types of the CPU pipeline
// the all-zero stage_rec_t is a bubble, so every enum starts its idle value at 0
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_BITS-1:0] word_t;  // data, address or instruction
    typedef logic [`CPU_REG_BITS-1:0]  reg_idx_t;
    typedef logic [2:0]                flags_t;  // N Z C, see CPU_FLAG_* positions

    typedef enum logic [`CPU_OPCODE_BITS-1:0] {
        op_mv    = 3'd0,
        op_mvt_b = 3'd1,  // mvt with imm flag set, branch otherwise
        op_add   = 3'd2,
        op_sub   = 3'd3,
        op_ld    = 3'd4,
        op_st    = 3'd5,
        op_logic = 3'd6,  // not implemented, decodes as a bubble
        op_cmp   = 3'd7
    } opcode_e;

    typedef enum logic [3:0] {
        instr_nop,
        instr_mov,
        instr_mvt,
        instr_branch,
        instr_add,
        instr_sub,
        instr_load,
        instr_store,
        instr_cmp
    } instr_e;

    typedef enum logic [1:0] {alu_none, alu_mov, alu_add, alu_sub} alu_op_e;

    // encoding matches the rX field of a branch; code 7 is folded into none
    typedef enum logic [2:0] {
        cond_none, cond_eq, cond_ne, cond_cc, cond_cs, cond_pl, cond_mi
    } cond_e;

    typedef struct packed {
        word_t    op1;           // rX value, or pc for a branch
        word_t    op2;           // immediate or rY value
        word_t    result;
        reg_idx_t rx;            // destination when writeback is set
        reg_idx_t ry;
        logic     uses_ry;
        logic     writeback;
        logic     read;
        logic     write;
        instr_e   instr;
        alu_op_e  alu_op;
        logic     update_flags;
        cond_e    cond;
    } stage_rec_t;

endpackage

//--- common/regfile_if.sv
// register file bundle shared by fetch, decode and the writeback path
// read data is combinational from the indices; writes land on the clock edge
`timescale 1ns/1ps

interface regfile_if;
    import cpu_pkg::*;

    reg_idx_t rd_x;
    reg_idx_t rd_y;
    word_t    rd_x_data;
    word_t    rd_y_data;
    word_t    pc;
    logic     pc_inc;     // bump r7 by one at the next edge
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    modport decode (output rd_x, rd_y, input rd_x_data, rd_y_data, pc);
    modport fetch (output pc_inc, input pc);
    modport writeback (output wb_en, wb_reg, wb_data);
    modport regs (
        input  rd_x, rd_y, pc_inc, wb_en, wb_reg, wb_data,
        output rd_x_data, rd_y_data, pc
    );

endinterface

//--- cpu/decode_unit.sv
// decode stage splits the instruction word and reads both operands
// a branch reads the pc as op1 and writes r7; opcode 6 and malformed cmp are bubbles
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::word_t      fetch_word,
    input  logic                dec_stall,
    input  logic                mem_wait,
    input  logic                flush,
    output cpu_pkg::reg_idx_t   dec_rx,
    output cpu_pkg::reg_idx_t   dec_ry,
    output logic                dec_uses_ry,
    output logic                dec_is_branch,
    output cpu_pkg::stage_rec_t decode_rec,
    regfile_if.decode           rf
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic       imm_flag;
    word_t      imm_ext;
    stage_rec_t dec_next;

    assign opcode   = opcode_e'(fetch_word[`CPU_WORD_BITS-1 -: `CPU_OPCODE_BITS]);
    assign imm_flag = fetch_word[`CPU_IMM_FLAG];
    assign dec_rx   = fetch_word[`CPU_RX_LSB +: `CPU_REG_BITS];
    assign dec_ry   = fetch_word[`CPU_RY_LSB +: `CPU_REG_BITS];
    assign imm_ext  = {{(`CPU_WORD_BITS-`CPU_IMM_BITS){fetch_word[`CPU_IMM_BITS-1]}},
                       fetch_word[`CPU_IMM_BITS-1:0]};

    assign rf.rd_x = dec_rx;
    assign rf.rd_y = dec_ry;

    always_comb begin
        dec_next = '0;
        if (fetch_word != '0) begin  // zero word is what reset and flush leave behind
            dec_next.rx        = dec_rx;
            dec_next.ry        = dec_ry;
            dec_next.uses_ry   = !imm_flag;
            dec_next.op1       = rf.rd_x_data;
            dec_next.op2       = imm_flag ? imm_ext : rf.rd_y_data;
            dec_next.writeback = 1'b1;
            case (opcode)
                op_mv: begin
                    dec_next.instr  = instr_mov;
                    dec_next.alu_op = alu_mov;
                end
                op_mvt_b: begin
                    dec_next.uses_ry = 1'b0;
                    if (imm_flag) begin
                        dec_next.instr  = instr_mvt;
                        dec_next.alu_op = alu_mov;
                        dec_next.op2    = {fetch_word[7:0], 8'h00};  // low byte to the top
                    end else begin
                        // rX field carries the condition and the target is pc+offset
                        dec_next.instr  = instr_branch;
                        dec_next.alu_op = alu_add;
                        dec_next.rx     = reg_idx_t'(`CPU_PC_REG);
                        dec_next.op1    = rf.pc;
                        dec_next.op2    = imm_ext;
                        dec_next.cond   = (dec_rx == 3'd7) ? cond_none : cond_e'(dec_rx);
                    end
                end
                op_add: begin
                    dec_next.instr  = instr_add;
                    dec_next.alu_op = alu_add;
                end
                op_sub: begin
                    dec_next.instr  = instr_sub;
                    dec_next.alu_op = alu_sub;
                end
                op_ld: begin
                    dec_next.instr = instr_load;
                    dec_next.read  = 1'b1;
                end
                op_st: begin
                    dec_next.instr     = instr_store;
                    dec_next.write     = 1'b1;
                    dec_next.writeback = 1'b0;
                end
                op_cmp: begin
                    if (imm_flag || fetch_word[`CPU_IMM_BITS-1:`CPU_REG_BITS] == '0) begin
                        dec_next.instr        = instr_cmp;
                        dec_next.alu_op       = alu_sub;
                        dec_next.update_flags = 1'b1;
                        dec_next.writeback    = 1'b0;
                    end else begin
                        dec_next = '0;
                    end
                end
                default: dec_next = '0;  // logic opcode
            endcase
        end
    end

    assign dec_uses_ry   = dec_next.uses_ry;
    assign dec_is_branch = dec_next.instr == instr_branch;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            decode_rec <= '0;
        end else if (!mem_wait) begin
            if (flush || dec_stall)
                decode_rec <= '0;
            else
                decode_rec <= dec_next;
        end
    end

    // a stalled word must still be waiting in fetch one cycle later
    a_word_held_on_stall: assert property (@(posedge Clock) disable iff (Reset)
        (dec_stall || mem_wait) && !flush |=> $stable(fetch_word));

endmodule

//--- cpu/execute_unit.sv
// execute stage with the ALU and its carry, the flags register and the condition check
// only cmp writes the flags; a failed condition leaves a bubble
// a taken branch flushes fetch and decode but nothing older
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::stage_rec_t decode_rec,
    input  logic                mem_wait,
    output logic                flush,
    output cpu_pkg::stage_rec_t exec_rec
);
    import cpu_pkg::*;

    flags_t     flags;
    word_t      alu_result;
    logic       alu_carry;  // borrow on sub
    logic       cond_met;
    stage_rec_t exec_next;

    always_comb begin
        alu_result = '0;
        alu_carry  = 1'b0;
        case (decode_rec.alu_op)
            alu_mov: alu_result = decode_rec.op2;
            alu_add: {alu_carry, alu_result} = {1'b0, decode_rec.op1} + {1'b0, decode_rec.op2};
            alu_sub: {alu_carry, alu_result} = {1'b0, decode_rec.op1} - {1'b0, decode_rec.op2};
            default: ;
        endcase
    end

    always_comb begin
        case (decode_rec.cond)
            cond_eq: cond_met = flags[`CPU_FLAG_Z];
            cond_ne: cond_met = !flags[`CPU_FLAG_Z];
            cond_cc: cond_met = !flags[`CPU_FLAG_C];
            cond_cs: cond_met = flags[`CPU_FLAG_C];
            cond_pl: cond_met = !flags[`CPU_FLAG_Z] && !flags[`CPU_FLAG_N];
            cond_mi: cond_met = !flags[`CPU_FLAG_Z] && flags[`CPU_FLAG_N];
            default: cond_met = 1'b1;
        endcase
    end

    always_comb begin
        exec_next        = decode_rec;
        exec_next.result = alu_result;
        if (!cond_met)
            exec_next = '0;
    end

    // held back while memory waits since decode would then lose the branch
    assign flush = cond_met && decode_rec.instr == instr_branch && !mem_wait;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exec_rec <= '0;
            flags    <= '0;
        end else if (!mem_wait) begin
            exec_rec <= exec_next;
            if (decode_rec.update_flags) begin
                flags[`CPU_FLAG_N] <= alu_result[`CPU_WORD_BITS-1];
                flags[`CPU_FLAG_Z] <= alu_result == '0;
                flags[`CPU_FLAG_C] <= alu_carry;
            end
        end
    end

    // the instruction behind a taken branch never reaches execute
    a_flush_clears_decode: assert property (@(posedge Clock) disable iff (Reset)
        flush |=> decode_rec == '0);

endmodule

//--- cpu/fetch_unit.sv
// fetch stage addresses the instruction at pc+1 and latches it
// the pc sits one behind the fetch address, so it resets to all ones
`timescale 1ns/1ps

module fetch_unit (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t InstrIn,
    output cpu_pkg::word_t InstrAddr,
    input  logic           dec_stall,
    input  logic           mem_wait,
    input  logic           flush,
    output cpu_pkg::word_t fetch_word,
    regfile_if.fetch       rf
);
    import cpu_pkg::*;

    logic stalled;

    assign stalled   = dec_stall || mem_wait;
    assign InstrAddr = stalled ? rf.pc : rf.pc + 1'b1;
    assign rf.pc_inc = !stalled;  // pc follows the word just taken

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fetch_word <= '0;
        end else if (flush) begin
            fetch_word <= '0;  // zero word decodes as a bubble
        end else if (!stalled) begin
            fetch_word <= InstrIn;
        end
    end

    // a taken branch always sits under the branch stall so the pc never moves past it
    a_no_inc_on_flush: assert property (@(posedge Clock) disable iff (Reset)
        flush |-> !rf.pc_inc);

endmodule

//--- cpu/hazard_unit.sv
// front-end stall, no forwarding paths exist
// decode waits until every older writer of its sources has left the memory register
// any branch still in flight also holds decode, since the pc is not yet known
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_idx_t   dec_rx,
    input  cpu_pkg::reg_idx_t   dec_ry,
    input  logic                dec_uses_ry,
    input  logic                dec_is_branch,
    input  cpu_pkg::stage_rec_t decode_rec,
    input  cpu_pkg::stage_rec_t exec_rec,
    input  cpu_pkg::stage_rec_t mem_rec,
    output logic                dec_stall
);
    import cpu_pkg::*;

    logic [2:0] raw_hit;  // decode, execute, memory register
    logic       branch_pending;

    // rX of a branch is a condition code, not a source
    function automatic logic raw_match(input stage_rec_t rec);
        return rec.writeback &&
               ((!dec_is_branch && rec.rx == dec_rx) || (dec_uses_ry && rec.rx == dec_ry));
    endfunction

    assign raw_hit[0] = raw_match(decode_rec);
    assign raw_hit[1] = raw_match(exec_rec);
    assign raw_hit[2] = raw_match(mem_rec);

    assign branch_pending = decode_rec.instr == instr_branch ||
                            exec_rec.instr == instr_branch ||
                            mem_rec.instr == instr_branch;

    assign dec_stall = |raw_hit || branch_pending;

endmodule

//--- cpu/memory_unit.sv
// memory stage, drives the data port straight from the execute register
// a request stays up until DataDone; meanwhile a bubble enters the memory register
`timescale 1ns/1ps

module memory_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::stage_rec_t exec_rec,
    input  cpu_pkg::word_t      DataIn,
    input  logic                DataDone,
    output cpu_pkg::word_t      DataAddr,
    output cpu_pkg::word_t      DataOut,
    output logic                ReadData,
    output logic                WriteData,
    output logic                mem_wait,
    output cpu_pkg::stage_rec_t mem_rec,
    regfile_if.writeback        rf
);
    import cpu_pkg::*;

    assign DataAddr  = exec_rec.op2;
    assign DataOut   = exec_rec.op1;  // store data is rX
    assign ReadData  = exec_rec.read;
    assign WriteData = exec_rec.write;
    assign mem_wait  = (exec_rec.read || exec_rec.write) && !DataDone;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_rec <= '0;
        end else if (mem_wait) begin
            mem_rec <= '0;
        end else begin
            mem_rec <= exec_rec;
            if (exec_rec.read)
                mem_rec.result <= DataIn;
        end
    end

    // writeback happens from the memory register at the next edge
    assign rf.wb_en   = mem_rec.writeback;
    assign rf.wb_reg  = mem_rec.rx;
    assign rf.wb_data = mem_rec.result;

    a_rd_wr_excl: assert property (@(posedge Clock) disable iff (Reset)
        !(ReadData && WriteData));

endmodule

//--- cpu/register_file.sv
// eight general registers, r7 is the pc and resets to all ones
// reads are combinational and see a write only after the edge
// on r7 a writeback (branch target) wins over the fetch increment
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file (
    input  logic     Clock,
    input  logic     Reset,
    regfile_if.regs  rf
);
    import cpu_pkg::*;

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
            regs[`CPU_PC_REG] <= '1;  // first fetch address is pc+1 = 0
        end else begin
            if (rf.pc_inc)
                regs[`CPU_PC_REG] <= regs[`CPU_PC_REG] + 1'b1;
            if (rf.wb_en)
                regs[rf.wb_reg] <= rf.wb_data;  // last assignment wins
        end
    end

    assign rf.rd_x_data = regs[rf.rd_x];
    assign rf.rd_y_data = regs[rf.rd_y];
    assign rf.pc        = regs[`CPU_PC_REG];

endmodule

//--- dv/cpu_tb.sv
// testbench for cpu_top that runs one fixed program and checks every store in order
// instruction memory answers combinationally and data memory after 0 to 3 cycles
// the program must fit in 256 words and end in a branch to itself
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    logic  Clock = 1'b0;
    logic  Reset = 1'b1;
    logic  DataDone = 1'b0;
    word_t DataIn = '0;
    word_t InstrIn;
    word_t InstrAddr;
    word_t DataAddr;
    word_t DataOut;
    logic  ReadData;
    logic  WriteData;

    word_t imem [256];
    word_t dmem [word_t];       // only words written by completed stores
    word_t exp_addr [$];
    word_t exp_data [$];
    int    n_instr = 0;
    int    ref_steps = 0;
    int    exp_total = 0;
    int    stores_seen = 0;
    int    timeout_cycles = 0;
    int    seed = 32'h3f0a;
    int    wait_left = -1;      // cycles until DataDone or -1 when idle
    word_t held_addr;
    logic  held_write;
    logic  mem_op_fetched = 1'b0;

    cpu_top cpu_top_i (
        .Clock, .Reset, .InstrIn, .DataIn, .DataDone,
        .InstrAddr, .DataAddr, .DataOut, .ReadData, .WriteData
    );

    always #2 Clock = ~Clock;

    assign InstrIn = imem[InstrAddr[7:0]];

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string name);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                    $time, name, exp, got));
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string name);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                    $time, name, exp, got));
    endtask

    // power-up contents of data memory with one preset word
    function automatic word_t init_word(input word_t a);
        return (a == 16'h0020) ? 16'hbeef : ({a[7:0], a[15:8]} ^ 16'h5a3c);
    endfunction

    function automatic word_t imm_instr(input int op, input int rx, input int imm);
        return {op[2:0], 1'b1, rx[2:0], imm[8:0]};
    endfunction

    function automatic word_t reg_instr(input int op, input int rx, input int ry);
        return {op[2:0], 1'b0, rx[2:0], 6'd0, ry[2:0]};
    endfunction

    function automatic word_t branch_instr(input int cond, input int offset);
        return {3'd1, 1'b0, cond[2:0], offset[8:0]};
    endfunction

    task automatic emit(input word_t w);
        imem[n_instr[7:0]] = w;
        n_instr++;
    endtask

    function automatic logic cond_true(input logic [2:0] code, input logic n,
                                       input logic z, input logic c);
        case (code)
            3'd1: return z;
            3'd2: return !z;
            3'd3: return !c;
            3'd4: return c;
            3'd5: return !z && !n;
            3'd6: return !z && n;
            default: return 1'b1;  // none and code 7
        endcase
    endfunction

    // architectural model that fills the expected store queues and returns -1 if it never halts
    function automatic int ref_run();
        word_t r [8];
        word_t mem [word_t];
        word_t pc;
        word_t ins;
        word_t imm;
        word_t op2;
        word_t diff;
        logic  fn;
        logic  fz;
        logic  fc;
        logic  halted;
        int    steps;
        r = '{default: '0};
        pc = '0;
        fn = 1'b0;
        fz = 1'b0;
        fc = 1'b0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 4000) begin
            ins = imem[pc[7:0]];
            imm = {{7{ins[8]}}, ins[8:0]};
            op2 = ins[12] ? imm : r[ins[2:0]];
            steps++;
            pc = pc + 16'd1;
            case (ins[15:13])
                3'd0: r[ins[11:9]] = op2;
                3'd1: begin
                    if (ins[12]) begin
                        r[ins[11:9]] = {ins[7:0], 8'h00};
                    end else if (cond_true(ins[11:9], fn, fz, fc)) begin
                        halted = imm == 16'hffff;  // branch to itself
                        pc = pc + imm;
                    end
                end
                3'd2: r[ins[11:9]] = r[ins[11:9]] + op2;
                3'd3: r[ins[11:9]] = r[ins[11:9]] - op2;
                3'd4: begin
                    if (mem.exists(op2))
                        r[ins[11:9]] = mem[op2];
                    else
                        r[ins[11:9]] = init_word(op2);
                end
                3'd5: begin
                    exp_addr.push_back(op2);
                    exp_data.push_back(r[ins[11:9]]);
                    mem[op2] = r[ins[11:9]];
                end
                3'd7: begin
                    if (ins[12] || ins[8:3] == 6'd0) begin  // malformed cmp does nothing
                        diff = r[ins[11:9]] - op2;
                        fn = diff[15];
                        fz = diff == 16'h0000;
                        fc = r[ins[11:9]] < op2;
                    end
                end
                default: ;  // logic opcode
            endcase
        end
        return halted ? steps : -1;
    endfunction

    task automatic load_program();
        int loop_top;
        imem = '{default: '0};
        emit(imm_instr(0, 1, 5));         // ALU ops in immediate and register forms
        emit(imm_instr(1, 2, 'h12));      // mvt
        emit(imm_instr(2, 2, 'h34));
        emit(reg_instr(0, 3, 2));
        emit(imm_instr(3, 3, -200));
        emit(reg_instr(2, 3, 1));
        emit(reg_instr(3, 1, 3));         // negative result
        emit(imm_instr(5, 2, 16));
        emit(imm_instr(5, 3, 17));
        emit(imm_instr(5, 1, 18));
        emit(imm_instr(0, 4, 7));         // back-to-back RAW chain
        emit(reg_instr(2, 4, 4));
        emit(reg_instr(2, 4, 4));
        emit(imm_instr(3, 4, 3));
        emit(imm_instr(5, 4, 19));
        emit(imm_instr(4, 5, 32));        // preset word
        emit(imm_instr(2, 5, 1));
        emit(imm_instr(5, 5, 33));
        emit(imm_instr(4, 6, 33));        // reads back the store
        emit(imm_instr(0, 0, 48));
        emit(reg_instr(4, 4, 0));         // register address
        emit(reg_instr(5, 4, 6));
        emit(imm_instr(4, 2, -2));        // address 0xfffe
        emit(imm_instr(5, 2, 34));
        emit({3'd6, 1'b1, 3'd1, 9'h0ff}); // logic opcode must leave r1 unchanged
        emit(imm_instr(5, 1, 35));
        emit(imm_instr(0, 1, 5));
        emit(imm_instr(0, 2, 9));
        emit(imm_instr(0, 6, 0));
        // every condition code against three flag settings
        for (int c = 0; c < 8; c++) begin
            for (int s = 0; s < 3; s++) begin
                case (s)
                    0: emit(reg_instr(7, 1, 1));  // zero
                    1: emit(reg_instr(7, 1, 2));  // negative with borrow
                    default: emit(imm_instr(7, 2, 5));
                endcase
                emit(branch_instr(c, 1));         // taken skips the increment
                emit(imm_instr(2, 6, 1));
                emit(imm_instr(5, 6, 64));
            end
        end
        emit(reg_instr(7, 1, 1));
        emit(reg_instr(7, 1, 2) | 16'h0008);     // malformed cmp keeps Z
        emit(branch_instr(1, 1));
        emit(imm_instr(2, 6, 1));
        emit(imm_instr(5, 6, 64));
        emit(imm_instr(0, 3, 4));                 // counted loop
        loop_top = n_instr;
        emit(imm_instr(5, 3, 80));
        emit(imm_instr(3, 3, 1));
        emit(imm_instr(7, 3, 0));
        emit(branch_instr(2, loop_top - n_instr - 1));
        emit(branch_instr(0, -1));
    endtask

    // data port responder driving its inputs on the falling edge
    always @(negedge Clock) begin
        if (!Reset) begin
            if (DataDone) begin
                DataDone = 1'b0;  // the last rising edge took the response
                wait_left = -1;
            end else if (wait_left >= 0 && !((ReadData || WriteData) &&
                         DataAddr == held_addr && WriteData == held_write)) begin
                stop_on_error("a data request was withdrawn before DataDone");
            end
            if (ReadData || WriteData) begin
                if (wait_left < 0) begin
                    wait_left = $random(seed) & 3;
                    held_addr = DataAddr;
                    held_write = WriteData;
                end
                if (wait_left == 0) begin
                    DataDone = 1'b1;
                    if (dmem.exists(DataAddr))
                        DataIn = dmem[DataAddr];
                    else
                        DataIn = init_word(DataAddr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge Clock) begin
        if ((ReadData || WriteData) && !mem_op_fetched)
            stop_on_error("ReadData or WriteData went high before any ld or st was fetched");
        if (!Reset && InstrIn[15:13] inside {3'd4, 3'd5})
            mem_op_fetched = 1'b1;
        if (!Reset && WriteData && DataDone) begin
            if (exp_addr.size() == 0) begin
                stop_on_error($sformatf("unexpected store of %h to address %h at %0t",
                                        DataOut, DataAddr, $time));
            end else begin
                check_addr(DataAddr, exp_addr.pop_front(), "DataAddr");
                check_data(DataOut, exp_data.pop_front(), "DataOut");
            end
            dmem[DataAddr] = DataOut;
            stores_seen++;
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge Clock);
        stop_on_error($sformatf("watchdog expired after %0d cycles, %0d of %0d stores seen",
                                timeout_cycles, stores_seen, exp_total));
    end

    initial begin
        load_program();
        ref_steps = ref_run();
        if (ref_steps < 0)
            stop_on_error("reference model never reached the final branch to itself");
        exp_total = exp_addr.size();
        timeout_cycles = 16 + 50 + 14 * ref_steps + 100;  // worst stall per instruction
        repeat (16) @(negedge Clock);
        Reset = 1'b0;
        #1;
        check_addr(InstrAddr, 16'h0000, "InstrAddr");
        wait (stores_seen == exp_total);
        repeat (50) @(posedge Clock);  // no extra store may follow
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/cpu_pkg.sv
common/regfile_if.sv
cpu/fetch_unit.sv
cpu/decode_unit.sv
cpu/hazard_unit.sv
cpu/execute_unit.sv
cpu/memory_unit.sv
cpu/register_file.sv
rtl/cpu_top.sv
dv/cpu_tb.sv

//--- rtl/cpu_top.sv
// five-stage 16-bit CPU, eight registers with r7 as program counter
// InstrIn must answer InstrAddr in the same cycle
// DataIn is sampled in the cycle DataDone is high; ReadData/WriteData hold until then
// no forwarding, RAW hazards and in-flight branches stall the front end
`timescale 1ns/1ps

module cpu_top (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t InstrIn,
    input  cpu_pkg::word_t DataIn,
    input  logic           DataDone,
    output cpu_pkg::word_t InstrAddr,
    output cpu_pkg::word_t DataAddr,
    output cpu_pkg::word_t DataOut,
    output logic           ReadData,
    output logic           WriteData
);
    import cpu_pkg::*;

    word_t      fetch_word;
    reg_idx_t   dec_rx;
    reg_idx_t   dec_ry;
    logic       dec_uses_ry;
    logic       dec_is_branch;
    stage_rec_t decode_rec;
    stage_rec_t exec_rec;
    stage_rec_t mem_rec;
    logic       dec_stall;
    logic       mem_wait;
    logic       flush;

    regfile_if rf_bus ();

    fetch_unit fetch_unit_i (
        .Clock, .Reset, .InstrIn, .InstrAddr,
        .dec_stall, .mem_wait, .flush, .fetch_word,
        .rf (rf_bus.fetch)
    );

    decode_unit decode_unit_i (
        .Clock, .Reset, .fetch_word,
        .dec_stall, .mem_wait, .flush,
        .dec_rx, .dec_ry, .dec_uses_ry, .dec_is_branch, .decode_rec,
        .rf (rf_bus.decode)
    );

    hazard_unit hazard_unit_i (
        .dec_rx, .dec_ry, .dec_uses_ry, .dec_is_branch,
        .decode_rec, .exec_rec, .mem_rec, .dec_stall
    );

    execute_unit execute_unit_i (
        .Clock, .Reset, .decode_rec, .mem_wait, .flush, .exec_rec
    );

    memory_unit memory_unit_i (
        .Clock, .Reset, .exec_rec, .DataIn, .DataDone,
        .DataAddr, .DataOut, .ReadData, .WriteData,
        .mem_wait, .mem_rec,
        .rf (rf_bus.writeback)
    );

    register_file register_file_i (
        .Clock, .Reset,
        .rf (rf_bus.regs)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the CPU and its testbench with Verilator and runs the simulation
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f project.f --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit $status
fi

./obj_dir/cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit $status
fi

exit 0
